/* hdl/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [2:0]  br_kind_t;

    // one-hot alu operation bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam br_kind_t BR_NONE = 3'd0;
    localparam br_kind_t BR_BEQ  = 3'd1;
    localparam br_kind_t BR_BNE  = 3'd2;
    localparam br_kind_t BR_J    = 3'd3;
    localparam br_kind_t BR_JAL  = 3'd4;
    localparam br_kind_t BR_JR   = 3'd5;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd31;

    localparam word_t PC_STEP = 32'd4;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fs_to_ds_t;

    // one forwarding source from execute, memory or writeback
    typedef struct packed {
        logic      valid;
        logic      gr_we;
        logic      is_load;
        reg_addr_t addr;
        word_t     value;
    } fw_src_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_8;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        imm_t      imm;
    } ds_ctrl_t;

    typedef struct packed {
        ds_ctrl_t ctrl;
        word_t    rs_value;
        word_t    rt_value;
        word_t    pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  ready;
        logic  taken;
        word_t target;
    } br_t;

endpackage

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  word_t       inst,
    output ds_ctrl_t    ctrl,
    output reg_addr_t   rs,
    output reg_addr_t   rt,
    output logic [25:0] jidx,
    output br_kind_t    br_kind
);

    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rd;
    logic [4:0] sa;
    logic       is_special;

    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_j, inst_jal, inst_jr;
    logic inst_known;
    logic dst_is_rt;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign jidx = inst[25:0];

    assign is_special = (op == OP_SPECIAL);

    // three-register forms need a zero shift amount
    assign inst_addu = is_special && func == FN_ADDU && sa == 5'd0;
    assign inst_subu = is_special && func == FN_SUBU && sa == 5'd0;
    assign inst_slt  = is_special && func == FN_SLT  && sa == 5'd0;
    assign inst_sltu = is_special && func == FN_SLTU && sa == 5'd0;
    assign inst_and  = is_special && func == FN_AND  && sa == 5'd0;
    assign inst_or   = is_special && func == FN_OR   && sa == 5'd0;
    assign inst_xor  = is_special && func == FN_XOR  && sa == 5'd0;
    assign inst_nor  = is_special && func == FN_NOR  && sa == 5'd0;

    // shifts by constant leave rs empty
    assign inst_sll  = is_special && func == FN_SLL && rs == REG_ZERO;
    assign inst_srl  = is_special && func == FN_SRL && rs == REG_ZERO;
    assign inst_sra  = is_special && func == FN_SRA && rs == REG_ZERO;

    assign inst_jr   = is_special && func == FN_JR && rt == REG_ZERO
                       && rd == REG_ZERO && sa == 5'd0;

    assign inst_addiu = (op == OP_ADDIU);
    assign inst_lui   = (op == OP_LUI) && rs == REG_ZERO;
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    assign inst_known = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and
                      | inst_or | inst_xor | inst_nor | inst_sll | inst_srl
                      | inst_sra | inst_addiu | inst_lui | inst_lw | inst_sw
                      | inst_beq | inst_bne | inst_j | inst_jal | inst_jr;

    // i-type writers target rt
    assign dst_is_rt = inst_addiu | inst_lui | inst_lw;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctrl.alu_op[ALU_SUB]  = inst_subu;
        ctrl.alu_op[ALU_SLT]  = inst_slt;
        ctrl.alu_op[ALU_SLTU] = inst_sltu;
        ctrl.alu_op[ALU_AND]  = inst_and;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or;
        ctrl.alu_op[ALU_XOR]  = inst_xor;
        ctrl.alu_op[ALU_SLL]  = inst_sll;
        ctrl.alu_op[ALU_SRL]  = inst_srl;
        ctrl.alu_op[ALU_SRA]  = inst_sra;
        ctrl.alu_op[ALU_LUI]  = inst_lui;

        ctrl.load_op     = inst_lw;
        ctrl.src1_is_sa  = inst_sll | inst_srl | inst_sra;
        // jal computes pc + 8 as its link value
        ctrl.src1_is_pc  = inst_jal;
        ctrl.src2_is_8   = inst_jal;
        ctrl.src2_is_imm = inst_addiu | inst_lui | inst_lw | inst_sw;
        ctrl.mem_we      = inst_sw;
        ctrl.gr_we       = inst_known & ~(inst_sw | inst_beq | inst_bne | inst_j | inst_jr);

        if (inst_known) begin
            ctrl.imm  = inst[15:0];
            ctrl.dest = inst_jal  ? REG_RA :
                        dst_is_rt ? rt     :
                                    rd;
        end
    end

    always_comb begin
        br_kind = BR_NONE;
        if (inst_beq) br_kind = BR_BEQ;
        if (inst_bne) br_kind = BR_BNE;
        if (inst_j)   br_kind = BR_J;
        if (inst_jal) br_kind = BR_JAL;
        if (inst_jr)  br_kind = BR_JR;
    end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile import decode_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  rf_write_t wr
);

    word_t mem [32];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != REG_ZERO) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // zero slot has no defined contents, so force it on read
    assign rdata1 = (raddr1 == REG_ZERO) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == REG_ZERO) ? '0 : mem[raddr2];

endmodule

/* hdl/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import decode_pkg::*; (
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fw_src_t   es_fw,
    input  fw_src_t   ms_fw,
    input  fw_src_t   ws_fw,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      stall
);

    logic es_load_hit;

    // true when a source writes the register being read
    function automatic logic hits(fw_src_t src, reg_addr_t addr);
        return src.valid && src.gr_we && src.addr == addr;
    endfunction

    // youngest producer wins; a load in execute has no value yet
    function automatic word_t pick(reg_addr_t addr, word_t rf_val,
                                   fw_src_t es, fw_src_t ms, fw_src_t ws);
        word_t val;
        if (addr == REG_ZERO)
            val = '0;
        else if (hits(es, addr) && !es.is_load)
            val = es.value;
        else if (hits(ms, addr))
            val = ms.value;
        else if (hits(ws, addr))
            val = ws.value;
        else
            val = rf_val;
        return val;
    endfunction

    assign rs_value = pick(raddr1, rf_rdata1, es_fw, ms_fw, ws_fw);
    assign rt_value = pick(raddr2, rf_rdata2, es_fw, ms_fw, ws_fw);

    // load-use: wait one cycle for the load to reach memory stage
    assign es_load_hit = es_fw.valid && es_fw.is_load && es_fw.addr != REG_ZERO;
    assign stall = es_load_hit && (es_fw.addr == raddr1 || es_fw.addr == raddr2);

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  br_kind_t    br_kind,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  imm_t        imm,
    input  logic [25:0] jidx,
    input  word_t       pc,
    output logic        taken,
    output word_t       target
);

    word_t pc_next;
    word_t br_offset;
    logic  rs_eq_rt;

    // decode pc + 4 is the delay slot address
    assign pc_next   = pc + PC_STEP;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    always_comb begin
        case (br_kind)
            BR_BEQ:               taken = rs_eq_rt;
            BR_BNE:               taken = !rs_eq_rt;
            BR_J, BR_JAL, BR_JR:  taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_J, BR_JAL: target = {pc_next[31:28], jidx, 2'b00};
            BR_JR:        target = rs_value;
            default:      target = pc_next + br_offset;
        endcase
    end

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ps

module id_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,

    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,

    // forwarding from later stages
    input  fw_src_t   es_fw,
    input  fw_src_t   ms_fw,
    input  fw_src_t   ws_fw,

    input  rf_write_t ws_to_rf,
    output br_t       br
);

    logic        ds_valid;
    logic        ds_ready_go;
    fs_to_ds_t   ds_buf;

    ds_ctrl_t    ctrl;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [25:0] jidx;
    br_kind_t    br_kind;

    word_t       rf_rdata1;
    word_t       rf_rdata2;
    word_t       rs_value;
    word_t       rt_value;
    logic        stall;

    logic        br_taken;
    word_t       br_target;

    assign ds_ready_go    = !stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    // empties when nothing new arrives while the old one leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_buf <= fs_to_ds;
        end
    end

    inst_decoder u_decoder (
        .inst    (ds_buf.inst),
        .ctrl    (ctrl),
        .rs      (rs),
        .rt      (rt),
        .jidx    (jidx),
        .br_kind (br_kind)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .rdata1 (rf_rdata1),
        .raddr2 (rt),
        .rdata2 (rf_rdata2),
        .wr     (ws_to_rf)
    );

    operand_bypass u_bypass (
        .raddr1    (rs),
        .raddr2    (rt),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_fw     (es_fw),
        .ms_fw     (ms_fw),
        .ws_fw     (ws_fw),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .br_kind  (br_kind),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .imm      (ctrl.imm),
        .jidx     (jidx),
        .pc       (ds_buf.pc),
        .taken    (br_taken),
        .target   (br_target)
    );

    assign ds_to_es.ctrl     = ctrl;
    assign ds_to_es.rs_value = rs_value;
    assign ds_to_es.rt_value = rt_value;
    assign ds_to_es.pc       = ds_buf.pc;

    // fetch ignores taken/target until the operands are settled
    assign br.ready  = ds_ready_go;
    assign br.taken  = ds_valid && br_taken;
    assign br.target = br_target;

endmodule

/* bench/id_stage_asserts.sv */
`timescale 1ns/1ps

module id_stage_asserts import decode_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      ds_valid,
    input logic      stall,
    input logic      es_allowin,
    input logic      ds_to_es_valid,
    input ds_to_es_t ds_to_es
);

    // failed assertion count
    int n_errors = 0;

    // stage comes out of reset empty
    reset_empties: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else begin
            $error("ds_to_es_valid high in the cycle after reset");
            n_errors++;
        end

    // bus must hold while execute is not taking it
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es))
        else begin
            $error("ds_to_es changed under back-pressure");
            n_errors++;
        end

    // a stalled instruction stays in the register
    stall_holds: assert property (@(posedge clk) disable iff (reset)
        ds_valid && stall |=> ds_valid && $stable(ds_to_es.pc) && $stable(ds_to_es.ctrl))
        else begin
            $error("instruction left the stage during a stall");
            n_errors++;
        end

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk            (clk),
    .reset          (reset),
    .ds_valid       (ds_valid),
    .stall          (stall),
    .es_allowin     (es_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es)
);

/* bench/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import decode_pkg::*; ();

    typedef struct {
        string    name;
        word_t    pc;
        word_t    inst;
        fw_src_t  es;
        fw_src_t  ms;
        fw_src_t  ws;
        int       hold;
        ds_ctrl_t ctrl;
        word_t    rs_val;
        word_t    rt_val;
        logic     stall;
        logic     taken;
        logic     chk_target;
        word_t    target;
    } test_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    fw_src_t   es_fw;
    fw_src_t   ms_fw;
    fw_src_t   ws_fw;
    rf_write_t ws_to_rf;
    br_t       br;

    test_t   tests[$];
    word_t   rf_model[32];
    word_t   lcg_state = 32'h1a50;
    bit      table_ready = 1'b0;
    bit      test_bad;
    int      n_pass = 0;
    int      n_fail = 0;
    longint  limit;

    id_stage dut0 (.*);

    always #50 clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sa, logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fw_src_t fw_src(logic valid, logic gr_we, logic is_load,
                                       reg_addr_t addr, word_t value);
        return '{valid, gr_we, is_load, addr, value};
    endfunction

    // reference operand selection, youngest producer first
    function automatic word_t model_operand(reg_addr_t a, fw_src_t es, fw_src_t ms, fw_src_t ws);
        if (a == REG_ZERO)
            return '0;
        if (es.valid && es.gr_we && !es.is_load && es.addr == a)
            return es.value;
        if (ms.valid && ms.gr_we && ms.addr == a)
            return ms.value;
        if (ws.valid && ws.gr_we && ws.addr == a)
            return ws.value;
        return rf_model[a];
    endfunction

    function automatic ds_ctrl_t mask_dest(ds_ctrl_t c);
        if (!c.gr_we)
            c.dest = '0;
        return c;
    endfunction

    // flags are {load_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, gr_we, mem_we}
    task automatic add_test(input string name, input word_t pc, input word_t inst,
                            input fw_src_t es, input fw_src_t ms, input fw_src_t ws,
                            input int hold, input int alu_bit, input logic [6:0] flags,
                            input reg_addr_t dest);
        test_t     t;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     nxt;
        rs = inst[25:21];
        rt = inst[20:16];
        t.name = name;
        t.pc = pc;
        t.inst = inst;
        t.es = es;
        t.ms = ms;
        t.ws = ws;
        t.hold = hold;
        t.stall = es.valid && es.is_load && es.addr != REG_ZERO
                  && (es.addr == rs || es.addr == rt);
        // operands expected once the load has moved on
        t.rs_val = model_operand(rs, t.stall ? fw_src_t'('0) : es, ms, ws);
        t.rt_val = model_operand(rt, t.stall ? fw_src_t'('0) : es, ms, ws);
        t.ctrl = '0;
        if (alu_bit >= 0)
            t.ctrl.alu_op[alu_bit] = 1'b1;
        {t.ctrl.load_op, t.ctrl.src1_is_sa, t.ctrl.src1_is_pc, t.ctrl.src2_is_imm,
         t.ctrl.src2_is_8, t.ctrl.gr_we, t.ctrl.mem_we} = flags;
        t.ctrl.dest = dest;
        t.ctrl.imm = inst[15:0];
        nxt = pc + 32'd4;
        t.taken = 1'b0;
        t.chk_target = 1'b1;
        t.target = '0;
        case (inst[31:26])
            OP_BEQ, OP_BNE: begin
                t.taken = (t.rs_val == t.rt_val) ^ (inst[31:26] == OP_BNE);
                t.target = nxt + {{14{inst[15]}}, inst[15:0], 2'b00};
            end
            OP_J, OP_JAL: begin
                t.taken = 1'b1;
                t.target = {nxt[31:28], inst[25:0], 2'b00};
            end
            OP_SPECIAL: begin
                t.chk_target = (inst[5:0] == FN_JR);
                t.taken = t.chk_target;
                t.target = t.rs_val;
            end
            default: t.chk_target = 1'b0;
        endcase
        tests.push_back(t);
    endtask

    task automatic check_val(string name, string what,
                             logic [$bits(ds_to_es_t)-1:0] exp,
                             logic [$bits(ds_to_es_t)-1:0] got);
        assert (got === exp) else begin
            $display("ERROR %s %s expected %0h actual %0h", name, what, exp, got);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_true(string name, logic cond, string msg);
        assert (cond === 1'b1) else begin
            $display("ERROR %s: %s", name, msg);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_outputs(test_t t);
        check_true(t.name, ds_to_es_valid, "instruction was not passed to execute");
        check_val(t.name, "ctrl", t.ctrl, mask_dest(ds_to_es.ctrl));
        check_val(t.name, "rs_value", t.rs_val, ds_to_es.rs_value);
        check_val(t.name, "rt_value", t.rt_val, ds_to_es.rt_value);
        check_val(t.name, "pc", t.pc, ds_to_es.pc);
        check_true(t.name, br.ready, "branch result not marked ready");
        check_val(t.name, "taken", t.taken, br.taken);
        if (t.chk_target)
            check_val(t.name, "target", t.target, br.target);
    endtask

    task automatic run_test(test_t t);
        int        waited;
        ds_to_es_t held;
        word_t     next_pc;
        test_bad = 1'b0;
        waited = 0;
        next_pc = t.pc + 32'h100;
        @(posedge clk);
        #5;
        fs_to_ds_valid = 1'b1;
        fs_to_ds = '{t.pc, t.inst};
        es_fw = t.es;
        ms_fw = t.ms;
        ws_fw = t.ws;
        es_allowin = (t.hold == 0);
        @(negedge clk);
        while (!ds_allowin && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        check_true(t.name, ds_allowin, "stage never accepted the instruction");
        @(posedge clk);
        #5;
        // under back-pressure the next instruction is already waiting
        fs_to_ds_valid = (t.hold > 0);
        fs_to_ds = '{next_pc, 32'h0};
        @(negedge clk);
        if (t.stall) begin
            repeat (3) begin
                check_true(t.name, !ds_to_es_valid, "instruction passed despite load-use hazard");
                check_true(t.name, !ds_allowin, "stage accepted input during a stall");
                check_true(t.name, !br.ready, "branch result ready during a stall");
                @(negedge clk);
            end
            @(posedge clk);
            #5;
            es_fw = '0;
            @(negedge clk);
        end
        check_outputs(t);
        held = ds_to_es;
        for (int i = 0; i < t.hold; i++) begin
            check_true(t.name, !ds_allowin, "stage accepted input under back-pressure");
            check_true(t.name, ds_to_es_valid, "instruction dropped under back-pressure");
            check_val(t.name, "held bus", held, ds_to_es);
            @(posedge clk);
            #5;
            if (i == t.hold - 1)
                es_allowin = 1'b1;
            @(negedge clk);
        end
        if (t.hold > 0) begin
            check_val(t.name, "held bus", held, ds_to_es);
            check_true(t.name, ds_allowin, "stage not ready after back-pressure ended");
            @(posedge clk);
            #5;
            fs_to_ds_valid = 1'b0;
            @(negedge clk);
            check_val(t.name, "next pc", next_pc, ds_to_es.pc);
        end
        @(posedge clk);
        #5;
        fs_to_ds_valid = 1'b0;
        es_allowin = 1'b1;
        es_fw = '0;
        ms_fw = '0;
        ws_fw = '0;
        waited = 0;
        @(negedge clk);
        while (ds_to_es_valid && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        check_true(t.name, !ds_to_es_valid, "stage did not drain");
        check_true(t.name, !br.taken, "branch taken while the stage is empty");
        if (test_bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("PASS %s", t.name);
        end
    endtask

    initial begin
        fw_src_t none;
        word_t   v;
        int      n_sva;
        none = '0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        es_fw = '0;
        ms_fw = '0;
        ws_fw = '0;
        ws_to_rf = '0;
        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        rf_model[0] = '0;
        // register 0 gets a write too and must still read zero
        for (int r = 0; r < 32; r++) begin
            v = lcg_next();
            ws_to_rf = '{1'b1, reg_addr_t'(r), v};
            if (r != 0)
                rf_model[r] = v;
            @(posedge clk);
            #5;
        end
        ws_to_rf = '0;

        add_test("addu", 32'h0040_0000, rtype(1, 2, 16, 0, FN_ADDU), none, none, none,
                 0, ALU_ADD, 7'b0000010, 16);
        add_test("subu", 32'h0040_0004, rtype(3, 4, 17, 0, FN_SUBU), none, none, none,
                 0, ALU_SUB, 7'b0000010, 17);
        add_test("slt", 32'h0040_0008, rtype(5, 6, 18, 0, FN_SLT), none, none, none,
                 0, ALU_SLT, 7'b0000010, 18);
        add_test("sltu", 32'h0040_000c, rtype(7, 8, 19, 0, FN_SLTU), none, none, none,
                 0, ALU_SLTU, 7'b0000010, 19);
        add_test("and", 32'h0040_0010, rtype(9, 10, 20, 0, FN_AND), none, none, none,
                 0, ALU_AND, 7'b0000010, 20);
        add_test("or", 32'h0040_0014, rtype(11, 12, 21, 0, FN_OR), none, none, none,
                 0, ALU_OR, 7'b0000010, 21);
        add_test("xor", 32'h0040_0018, rtype(13, 14, 22, 0, FN_XOR), none, none, none,
                 0, ALU_XOR, 7'b0000010, 22);
        add_test("nor", 32'h0040_001c, rtype(15, 1, 23, 0, FN_NOR), none, none, none,
                 0, ALU_NOR, 7'b0000010, 23);
        add_test("sll", 32'h0040_0020, rtype(0, 2, 24, 5, FN_SLL), none, none, none,
                 0, ALU_SLL, 7'b0100010, 24);
        add_test("srl", 32'h0040_0024, rtype(0, 3, 25, 31, FN_SRL), none, none, none,
                 0, ALU_SRL, 7'b0100010, 25);
        add_test("sra", 32'h0040_0028, rtype(0, 4, 26, 7, FN_SRA), none, none, none,
                 0, ALU_SRA, 7'b0100010, 26);
        add_test("addiu", 32'h0040_002c, itype(OP_ADDIU, 5, 27, 16'h8004), none, none, none,
                 0, ALU_ADD, 7'b0001010, 27);
        add_test("lui", 32'h0040_0030, itype(OP_LUI, 0, 28, 16'h1234), none, none, none,
                 0, ALU_LUI, 7'b0001010, 28);
        add_test("lw", 32'h0040_0034, itype(OP_LW, 6, 29, 16'hfffc), none, none, none,
                 0, ALU_ADD, 7'b1001010, 29);
        add_test("sw", 32'h0040_0038, itype(OP_SW, 7, 8, 16'h0010), none, none, none,
                 0, ALU_ADD, 7'b0001001, 0);
        add_test("reg_zero", 32'h0040_003c, rtype(0, 0, 9, 0, FN_ADDU), none, none,
                 fw_src(1, 1, 0, 0, lcg_next()), 0, ALU_ADD, 7'b0000010, 9);
        add_test("bypass_es_wins", 32'h0040_0040, rtype(3, 3, 10, 0, FN_ADDU),
                 fw_src(1, 1, 0, 3, lcg_next()), fw_src(1, 1, 0, 3, lcg_next()),
                 fw_src(1, 1, 0, 3, lcg_next()), 0, ALU_ADD, 7'b0000010, 10);
        add_test("bypass_ms_ws", 32'h0040_0044, rtype(4, 5, 11, 0, FN_ADDU),
                 fw_src(1, 1, 0, 6, lcg_next()), fw_src(1, 1, 0, 4, lcg_next()),
                 fw_src(1, 1, 0, 5, lcg_next()), 0, ALU_ADD, 7'b0000010, 11);
        add_test("bypass_none", 32'h0040_0048, rtype(1, 2, 12, 0, FN_ADDU),
                 fw_src(1, 1, 0, 12, lcg_next()), fw_src(1, 0, 0, 1, lcg_next()),
                 fw_src(0, 1, 0, 2, lcg_next()), 0, ALU_ADD, 7'b0000010, 12);
        add_test("load_use_stall", 32'h0040_004c, rtype(6, 7, 12, 0, FN_ADDU),
                 fw_src(1, 1, 1, 6, lcg_next()), none, none, 0, ALU_ADD, 7'b0000010, 12);
        add_test("load_ms_wins", 32'h0040_0050, rtype(3, 4, 13, 0, FN_ADDU),
                 fw_src(1, 1, 1, 3, lcg_next()), fw_src(1, 1, 0, 3, lcg_next()), none,
                 0, ALU_ADD, 7'b0000010, 13);
        add_test("beq_taken", 32'h0040_0054, itype(OP_BEQ, 5, 5, 16'h0010), none, none, none,
                 0, -1, 7'b0, 0);
        add_test("beq_not_taken", 32'h0040_0058, itype(OP_BEQ, 5, 6, 16'hfff0),
                 none, none, none, 0, -1, 7'b0, 0);
        add_test("bne_taken", 32'h0040_005c, itype(OP_BNE, 5, 6, 16'h0020), none, none, none,
                 0, -1, 7'b0, 0);
        add_test("bne_not_taken", 32'h0040_0060, itype(OP_BNE, 7, 7, 16'h8000),
                 none, none, none, 0, -1, 7'b0, 0);
        add_test("j", 32'hb000_1000, {OP_J, 26'h123_4567}, none, none, none, 0, -1, 7'b0, 0);
        add_test("jal", 32'h7fff_fffc, {OP_JAL, 26'h3ff_ffff}, none, none, none,
                 0, ALU_ADD, 7'b0010110, 31);
        add_test("jr", 32'h0040_0064, rtype(9, 0, 0, 0, FN_JR), none, none, none,
                 0, -1, 7'b0, 0);
        add_test("jr_bypass", 32'h0040_0068, rtype(9, 0, 0, 0, FN_JR), none,
                 fw_src(1, 1, 0, 9, lcg_next()), none, 0, -1, 7'b0, 0);
        add_test("backpressure_addu", 32'h0040_006c, rtype(1, 2, 3, 0, FN_ADDU), none, none, none,
                 3, ALU_ADD, 7'b0000010, 3);
        add_test("backpressure_lw", 32'h0040_0070, itype(OP_LW, 8, 14, 16'h0040), none, none, none,
                 1, ALU_ADD, 7'b1001010, 14);
        table_ready = 1'b1;

        foreach (tests[i])
            run_test(tests[i]);

        n_sva = dut0.u_asserts.n_errors;
        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 n_pass, n_fail, n_sva);
        if (n_fail == 0 && n_sva == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // each test needs well under 20 cycles
    initial begin
        wait (table_ready);
        limit = (longint'(tests.size()) * 20 + 50) * 100;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* build.f */
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
bench/id_stage_asserts.sv
bench/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/inst_decoder.sv
  - hdl/regfile.sv
  - hdl/operand_bypass.sv
  - hdl/branch_unit.sv
  - hdl/id_stage.sv
  - target: simulation
    files:
      - bench/id_stage_asserts.sv
      - bench/id_stage_tb.sv
